/* hdl/mipsPkg.sv */
package mipsPkg;

    localparam int dataWidth = 32;
    localparam int regAddrWidth = 5;
    localparam int byteEnableWidth = dataWidth / 8;

    localparam logic [dataWidth-1:0] resetVector = 32'hBFC0_0000;
    localparam logic [dataWidth-1:0] haltAddress = '0;   // Jump here to stop
    localparam logic [regAddrWidth-1:0] v0Index = 5'd2;

    // Major opcodes, bits 31:26
    typedef enum logic [5:0] {
        opSpecial = 6'd0,
        opJ       = 6'd2,
        opBeq     = 6'd4,
        opBne     = 6'd5,
        opAddiu   = 6'd9,
        opSlti    = 6'd10,
        opSltiu   = 6'd11,
        opAndi    = 6'd12,
        opOri     = 6'd13,
        opXori    = 6'd14,
        opLui     = 6'd15,
        opLw      = 6'd35,
        opSw      = 6'd43
    } opcodeT;

    // SPECIAL function field, bits 5:0
    typedef enum logic [5:0] {
        fnSll  = 6'd0,
        fnSrl  = 6'd2,
        fnSra  = 6'd3,
        fnJr   = 6'd8,
        fnAddu = 6'd33,
        fnSubu = 6'd35,
        fnAnd  = 6'd36,
        fnOr   = 6'd37,
        fnXor  = 6'd38,
        fnSlt  = 6'd42,
        fnSltu = 6'd43
    } functT;

    typedef enum logic [2:0] {
        fetch, decode, execute, memory, writeBack, halted
    } cpuStateT;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSlt, aluSltu,
        aluSll, aluSrl, aluSra, aluLui
    } aluOpT;

    typedef enum logic [2:0] {
        aluReg, aluImm, load, store, branchEq, branchNe, jump, jumpReg
    } instrClassT;

    typedef struct packed {
        instrClassT instrClass;
        aluOpT aluOp;
        logic [regAddrWidth-1:0] rs;
        logic [regAddrWidth-1:0] rt;
        logic [regAddrWidth-1:0] dest;     // rd for R-type, rt otherwise
        logic [4:0] shamt;
        logic [15:0] imm16;
        logic [25:0] target26;
        logic signExt;                     // Zero-extend when low
    } decodedT;

    typedef struct packed {
        logic [dataWidth-1:0] address;
        logic read;
        logic write;
        logic [dataWidth-1:0] writedata;
    } busReqT;

endpackage

/* hdl/controlFsm.sv */
`timescale 1ns/1ps

module controlFsm (
    input  logic clk,
    input  logic reset,
    input  logic waitrequest,
    input  mipsPkg::decodedT decoded,
    input  logic [mipsPkg::dataWidth-1:0] rsValue,
    input  logic [mipsPkg::dataWidth-1:0] rtValue,
    input  logic [mipsPkg::dataWidth-1:0] aluResult,
    input  logic [mipsPkg::dataWidth-1:0] readdata,
    input  logic [mipsPkg::dataWidth-1:0] pc,
    input  logic haltNow,
    output mipsPkg::busReqT busReq,
    output logic irLoad,
    output logic aluLoad,
    output logic pcAdvance,
    output logic regWrite,
    output logic [mipsPkg::dataWidth-1:0] regWriteData,
    output logic readV0,
    output logic active,
    output logic [mipsPkg::dataWidth-1:0] registerV0
);

    mipsPkg::cpuStateT state;
    logic [mipsPkg::dataWidth-1:0] memAddress;
    logic [mipsPkg::dataWidth-1:0] loadData;
    logic isAlu;
    logic isBranch;
    logic isLoad;
    logic isStore;

    assign isAlu = decoded.instrClass inside {mipsPkg::aluReg, mipsPkg::aluImm};
    assign isBranch = decoded.instrClass inside {mipsPkg::branchEq, mipsPkg::branchNe,
                                                 mipsPkg::jump, mipsPkg::jumpReg};
    assign isLoad = (decoded.instrClass == mipsPkg::load);
    assign isStore = (decoded.instrClass == mipsPkg::store);

    // Base plus sign-extended offset
    assign memAddress = rsValue + {{16{decoded.imm16[15]}}, decoded.imm16};

    always_comb begin
        busReq.address = pc;
        busReq.read = 1'b0;
        busReq.write = 1'b0;
        busReq.writedata = '0;
        irLoad = 1'b0;
        aluLoad = 1'b0;
        pcAdvance = 1'b0;
        regWrite = 1'b0;
        readV0 = 1'b0;
        regWriteData = isLoad ? loadData : aluResult;
        case (state)
            mipsPkg::fetch: begin
                busReq.read = !haltNow;   // No fetch from the halt address
                readV0 = haltNow;
                irLoad = !haltNow && !waitrequest;
            end
            mipsPkg::execute: begin
                aluLoad = isAlu;
                pcAdvance = isBranch;   // Branches and jumps end here
            end
            mipsPkg::memory: begin
                busReq.address = memAddress;
                busReq.read = isLoad;
                busReq.write = isStore;
                busReq.writedata = rtValue;
                pcAdvance = isStore && !waitrequest;
            end
            mipsPkg::writeBack: begin
                regWrite = 1'b1;
                pcAdvance = 1'b1;
            end
            mipsPkg::halted: readV0 = 1'b1;
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= mipsPkg::fetch;
            active <= 1'b1;
            registerV0 <= '0;
        end else begin
            case (state)
                mipsPkg::fetch: begin
                    if (haltNow) begin
                        state <= mipsPkg::halted;
                        active <= 1'b0;
                        registerV0 <= rsValue;   // rs index forced to v0
                    end else if (!waitrequest) begin
                        state <= mipsPkg::decode;
                    end
                end
                mipsPkg::decode: state <= mipsPkg::execute;
                mipsPkg::execute: begin
                    if (isBranch)
                        state <= mipsPkg::fetch;
                    else if (isLoad || isStore)
                        state <= mipsPkg::memory;
                    else
                        state <= mipsPkg::writeBack;
                end
                mipsPkg::memory: begin
                    if (!waitrequest)
                        state <= isStore ? mipsPkg::fetch : mipsPkg::writeBack;
                end
                mipsPkg::writeBack: state <= mipsPkg::fetch;
                mipsPkg::halted: registerV0 <= rsValue;
                default: state <= mipsPkg::fetch;
            endcase
        end
    end

    // Load word captured on the completing read
    always_ff @(posedge clk) begin
        if (state == mipsPkg::memory && !waitrequest)
            loadData <= readdata;
    end

endmodule

/* hdl/instrDecode.sv */
`timescale 1ns/1ps

module instrDecode (
    input  logic clk,
    input  logic reset,
    input  logic irLoad,
    input  logic [mipsPkg::dataWidth-1:0] readdata,
    output mipsPkg::decodedT decoded
);

    logic [mipsPkg::dataWidth-1:0] ir;
    mipsPkg::opcodeT opcode;
    mipsPkg::functT funct;

    // Cleared IR reads as the no-op SLL $0
    always_ff @(posedge clk) begin
        if (reset)
            ir <= '0;
        else if (irLoad)
            ir <= readdata;
    end

    assign opcode = mipsPkg::opcodeT'(ir[31:26]);
    assign funct = mipsPkg::functT'(ir[5:0]);

    always_comb begin
        decoded.rs = ir[25:21];
        decoded.rt = ir[20:16];
        decoded.dest = ir[20:16];
        decoded.shamt = ir[10:6];
        decoded.imm16 = ir[15:0];
        decoded.target26 = ir[25:0];
        decoded.instrClass = mipsPkg::aluImm;
        decoded.aluOp = mipsPkg::aluAdd;
        decoded.signExt = 1'b1;
        case (opcode)
            mipsPkg::opSpecial: begin
                decoded.instrClass = mipsPkg::aluReg;
                decoded.dest = ir[15:11];
                case (funct)
                    mipsPkg::fnAddu: decoded.aluOp = mipsPkg::aluAdd;
                    mipsPkg::fnSubu: decoded.aluOp = mipsPkg::aluSub;
                    mipsPkg::fnAnd:  decoded.aluOp = mipsPkg::aluAnd;
                    mipsPkg::fnOr:   decoded.aluOp = mipsPkg::aluOr;
                    mipsPkg::fnXor:  decoded.aluOp = mipsPkg::aluXor;
                    mipsPkg::fnSlt:  decoded.aluOp = mipsPkg::aluSlt;
                    mipsPkg::fnSltu: decoded.aluOp = mipsPkg::aluSltu;
                    mipsPkg::fnSll:  decoded.aluOp = mipsPkg::aluSll;
                    mipsPkg::fnSrl:  decoded.aluOp = mipsPkg::aluSrl;
                    mipsPkg::fnSra:  decoded.aluOp = mipsPkg::aluSra;
                    mipsPkg::fnJr:   decoded.instrClass = mipsPkg::jumpReg;
                    default:         decoded.dest = '0;   // Harmless ADDU to $0
                endcase
            end
            mipsPkg::opJ:     decoded.instrClass = mipsPkg::jump;
            mipsPkg::opBeq:   decoded.instrClass = mipsPkg::branchEq;
            mipsPkg::opBne:   decoded.instrClass = mipsPkg::branchNe;
            mipsPkg::opAddiu: decoded.aluOp = mipsPkg::aluAdd;
            mipsPkg::opSlti:  decoded.aluOp = mipsPkg::aluSlt;
            mipsPkg::opSltiu: decoded.aluOp = mipsPkg::aluSltu;
            mipsPkg::opAndi: begin
                decoded.aluOp = mipsPkg::aluAnd;
                decoded.signExt = 1'b0;
            end
            mipsPkg::opOri: begin
                decoded.aluOp = mipsPkg::aluOr;
                decoded.signExt = 1'b0;
            end
            mipsPkg::opXori: begin
                decoded.aluOp = mipsPkg::aluXor;
                decoded.signExt = 1'b0;
            end
            mipsPkg::opLui: decoded.aluOp = mipsPkg::aluLui;
            mipsPkg::opLw:  decoded.instrClass = mipsPkg::load;
            mipsPkg::opSw:  decoded.instrClass = mipsPkg::store;
            default: begin
                // Unsupported opcode becomes ADDU to $0
                decoded.instrClass = mipsPkg::aluReg;
                decoded.dest = '0;
            end
        endcase
    end

endmodule

/* hdl/regFile.sv */
`timescale 1ns/1ps

module regFile (
    input  logic clk,
    input  logic reset,
    input  logic [mipsPkg::regAddrWidth-1:0] rsIndex,
    input  logic [mipsPkg::regAddrWidth-1:0] rtIndex,
    input  logic readV0,
    input  logic regWrite,
    input  logic [mipsPkg::regAddrWidth-1:0] writeIndex,
    input  logic [mipsPkg::dataWidth-1:0] writeData,
    output logic [mipsPkg::dataWidth-1:0] rsValue,
    output logic [mipsPkg::dataWidth-1:0] rtValue
);

    localparam int numRegs = 2 ** mipsPkg::regAddrWidth;

    logic [mipsPkg::dataWidth-1:0] regs [numRegs];
    logic [mipsPkg::regAddrWidth-1:0] rsSel;

    assign rsSel = readV0 ? mipsPkg::v0Index : rsIndex;   // v0 readout on halt

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < numRegs; i++)
                regs[i] <= '0;
        end else if (regWrite && writeIndex != '0) begin
            regs[writeIndex] <= writeData;
        end
    end

    // $0 hardwired to zero
    assign rsValue = (rsSel == '0) ? '0 : regs[rsSel];
    assign rtValue = (rtIndex == '0) ? '0 : regs[rtIndex];

endmodule

/* hdl/alu.sv */
`timescale 1ns/1ps

module alu (
    input  logic clk,
    input  logic aluLoad,
    input  mipsPkg::decodedT decoded,
    input  logic [mipsPkg::dataWidth-1:0] rsValue,
    input  logic [mipsPkg::dataWidth-1:0] rtValue,
    output logic [mipsPkg::dataWidth-1:0] aluResult
);

    logic [mipsPkg::dataWidth-1:0] immExt;
    logic [mipsPkg::dataWidth-1:0] operandB;
    logic [mipsPkg::dataWidth-1:0] result;

    assign immExt = decoded.signExt ? {{16{decoded.imm16[15]}}, decoded.imm16}
                                    : {16'b0, decoded.imm16};

    // R-type takes rt and everything else the immediate
    assign operandB = (decoded.instrClass == mipsPkg::aluReg) ? rtValue : immExt;

    always_comb begin
        case (decoded.aluOp)
            mipsPkg::aluAdd: result = rsValue + operandB;
            mipsPkg::aluSub: result = rsValue - operandB;
            mipsPkg::aluAnd: result = rsValue & operandB;
            mipsPkg::aluOr:  result = rsValue | operandB;
            mipsPkg::aluXor: result = rsValue ^ operandB;
            mipsPkg::aluSlt: begin
                result = {{(mipsPkg::dataWidth-1){1'b0}},
                          $signed(rsValue) < $signed(operandB)};
            end
            mipsPkg::aluSltu: begin
                result = {{(mipsPkg::dataWidth-1){1'b0}}, rsValue < operandB};
            end
            // Shifts work on rt by shamt
            mipsPkg::aluSll: result = rtValue << decoded.shamt;
            mipsPkg::aluSrl: result = rtValue >> decoded.shamt;
            mipsPkg::aluSra: result = $signed(rtValue) >>> decoded.shamt;
            mipsPkg::aluLui: result = {decoded.imm16, 16'b0};
            default:         result = '0;
        endcase
    end

    // Captured at the end of execute
    always_ff @(posedge clk) begin
        if (aluLoad)
            aluResult <= result;
    end

endmodule

/* hdl/pcUnit.sv */
`timescale 1ns/1ps

module pcUnit (
    input  logic clk,
    input  logic reset,
    input  logic pcAdvance,
    input  mipsPkg::decodedT decoded,
    input  logic [mipsPkg::dataWidth-1:0] rsValue,
    input  logic [mipsPkg::dataWidth-1:0] rtValue,
    output logic [mipsPkg::dataWidth-1:0] pc,
    output logic haltNow
);

    logic [mipsPkg::dataWidth-1:0] pcPlus4;
    logic [mipsPkg::dataWidth-1:0] branchOffset;
    logic [mipsPkg::dataWidth-1:0] targetNow;
    logic [mipsPkg::dataWidth-1:0] pendingTarget;
    logic takenNow;
    logic pendingValid;   // Target waits for the delay slot

    assign pcPlus4 = pc + 32'd4;
    assign branchOffset = {{14{decoded.imm16[15]}}, decoded.imm16, 2'b00};

    // Only meaningful while a branch or jump sits in execute
    always_comb begin
        takenNow = 1'b0;
        targetNow = pcPlus4 + branchOffset;
        case (decoded.instrClass)
            mipsPkg::branchEq: takenNow = (rsValue == rtValue);
            mipsPkg::branchNe: takenNow = (rsValue != rtValue);
            mipsPkg::jump: begin
                takenNow = 1'b1;
                targetNow = {pcPlus4[31:28], decoded.target26, 2'b00};
            end
            mipsPkg::jumpReg: begin
                takenNow = 1'b1;
                targetNow = rsValue;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= mipsPkg::resetVector;
            pendingValid <= 1'b0;
        end else if (pcAdvance) begin
            pc <= pendingValid ? pendingTarget : pcPlus4;
            pendingValid <= takenNow;
        end
    end

    always_ff @(posedge clk) begin
        if (pcAdvance && takenNow)
            pendingTarget <= targetNow;
    end

    assign haltNow = (pc == mipsPkg::haltAddress);

endmodule

/* hdl/mipsCpuBus.sv */
`timescale 1ns/1ps

module mipsCpuBus (
    input  logic clk,
    input  logic reset,
    output logic active,
    output logic [mipsPkg::dataWidth-1:0] registerV0,

    // Avalon-MM master
    output logic [mipsPkg::dataWidth-1:0] address,
    output logic write,
    output logic read,
    input  logic waitrequest,
    output logic [mipsPkg::dataWidth-1:0] writedata,
    output logic [mipsPkg::byteEnableWidth-1:0] byteenable,
    input  logic [mipsPkg::dataWidth-1:0] readdata
);

    mipsPkg::busReqT busReq;
    mipsPkg::decodedT decoded;
    logic [mipsPkg::dataWidth-1:0] rsValue;
    logic [mipsPkg::dataWidth-1:0] rtValue;
    logic [mipsPkg::dataWidth-1:0] aluResult;
    logic [mipsPkg::dataWidth-1:0] pc;
    logic [mipsPkg::dataWidth-1:0] regWriteData;
    logic haltNow;
    logic irLoad;
    logic aluLoad;
    logic pcAdvance;
    logic regWrite;
    logic readV0;

    assign address = busReq.address;
    assign read = busReq.read;
    assign write = busReq.write;
    assign writedata = busReq.writedata;
    assign byteenable = '1;   // Word accesses only

    controlFsm controlFsm_i (
        .clk(clk), .reset(reset), .waitrequest(waitrequest),
        .decoded(decoded), .rsValue(rsValue), .rtValue(rtValue),
        .aluResult(aluResult), .readdata(readdata), .pc(pc), .haltNow(haltNow),
        .busReq(busReq), .irLoad(irLoad), .aluLoad(aluLoad), .pcAdvance(pcAdvance),
        .regWrite(regWrite), .regWriteData(regWriteData), .readV0(readV0),
        .active(active), .registerV0(registerV0)
    );

    instrDecode instrDecode_i (
        .clk(clk), .reset(reset), .irLoad(irLoad), .readdata(readdata),
        .decoded(decoded)
    );

    regFile regFile_i (
        .clk(clk), .reset(reset), .rsIndex(decoded.rs), .rtIndex(decoded.rt),
        .readV0(readV0), .regWrite(regWrite), .writeIndex(decoded.dest),
        .writeData(regWriteData), .rsValue(rsValue), .rtValue(rtValue)
    );

    alu alu_i (
        .clk(clk), .aluLoad(aluLoad), .decoded(decoded),
        .rsValue(rsValue), .rtValue(rtValue), .aluResult(aluResult)
    );

    pcUnit pcUnit_i (
        .clk(clk), .reset(reset), .pcAdvance(pcAdvance), .decoded(decoded),
        .rsValue(rsValue), .rtValue(rtValue), .pc(pc), .haltNow(haltNow)
    );

endmodule

/* dv/avalonMem.sv */
`timescale 1ns/1ps

module avalonMem (
    input  logic clk,
    input  logic [31:0] address,
    input  logic read,
    input  logic write,
    input  logic [31:0] writedata,
    output logic waitrequest,
    output logic [31:0] readdata
);

    localparam int idxBits = 8;
    localparam int memWords = 2 ** idxBits;
    localparam logic [31:0] dataBase = 32'h0000_1000;

    logic [31:0] progMem [memWords];   // Loaded by the testbench
    logic [31:0] dataMem [memWords];
    logic busy;
    int waitLeft;

    function automatic int wordIndex(input logic [31:0] addr, input logic [31:0] base);
        logic [31:0] offset;
        offset = (addr - base) >> 2;
        return int'(offset[idxBits-1:0]);
    endfunction

    // Boot segment holds the program and the rest is data
    function automatic logic inProgram(input logic [31:0] addr);
        return addr[31:28] == mipsPkg::resetVector[31:28];
    endfunction

    initial begin
        waitrequest = 1'b0;
        readdata = '0;
        busy = 1'b0;
        waitLeft = 0;
    end

    always @(posedge clk) begin
        #1;
        if ((read || write) && !busy) begin
            busy = 1'b1;
            waitLeft = int'($urandom_range(3, 0));   // Stall length for this access
        end
        if (busy && waitLeft > 0) begin
            waitrequest = 1'b1;
            waitLeft--;
        end else if (busy) begin
            waitrequest = 1'b0;   // Access completes this cycle
            busy = 1'b0;
            if (read) begin
                if (inProgram(address))
                    readdata = progMem[wordIndex(address, mipsPkg::resetVector)];
                else
                    readdata = dataMem[wordIndex(address, dataBase)];
            end
            if (write)
                dataMem[wordIndex(address, dataBase)] = writedata;
        end else begin
            waitrequest = 1'b0;
        end
    end

endmodule

/* dv/tbMipsCpuBus.sv */
`timescale 1ns/1ps

module tbMipsCpuBus;

    localparam int clkPeriod = 4;
    localparam int resetCycles = 8;
    localparam int numRandomTests = 3;
    localparam int numTests = numRandomTests + 2;
    localparam int maxInstr = 64;
    localparam int phases = 5;
    localparam int maxWait = 4;   // One cycle plus up to three stalls
    localparam int idxBits = 8;
    localparam int memWords = 2 ** idxBits;
    localparam logic [31:0] dataBase = 32'h0000_1000;

    logic clk;
    logic reset;
    logic waitrequest;
    logic [31:0] readdata;
    logic active;
    logic [31:0] registerV0;
    logic [31:0] address;
    logic read;
    logic write;
    logic [31:0] writedata;
    logic [3:0] byteenable;

    logic [31:0] prog [memWords];
    int progLen;
    logic [31:0] modelRegs [32];
    logic [31:0] modelData [memWords];
    logic [31:0] expAddr [$];     // Stores predicted by the model, in order
    logic [31:0] expData [$];
    int errors;
    int testsRun;
    int testsFailed;

    mipsPkg::busReqT curReq;
    mipsPkg::busReqT prevReq;
    logic prevWait;
    logic haltSeen;

    mipsPkg::functT aluFuncts [10] = '{mipsPkg::fnAddu, mipsPkg::fnSubu, mipsPkg::fnAnd,
        mipsPkg::fnOr, mipsPkg::fnXor, mipsPkg::fnSlt, mipsPkg::fnSltu,
        mipsPkg::fnSll, mipsPkg::fnSrl, mipsPkg::fnSra};
    mipsPkg::opcodeT immOps [7] = '{mipsPkg::opAddiu, mipsPkg::opAndi, mipsPkg::opOri,
        mipsPkg::opXori, mipsPkg::opLui, mipsPkg::opSlti, mipsPkg::opSltiu};

    mipsCpuBus mipsCpuBus_i (
        .clk(clk), .reset(reset), .active(active), .registerV0(registerV0),
        .address(address), .write(write), .read(read), .waitrequest(waitrequest),
        .writedata(writedata), .byteenable(byteenable), .readdata(readdata)
    );

    avalonMem avalonMem_i (
        .clk(clk), .address(address), .read(read), .write(write),
        .writedata(writedata), .waitrequest(waitrequest), .readdata(readdata)
    );

    initial clk = 1'b0;
    always #(clkPeriod / 2) clk = ~clk;

    task automatic reportMismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        $display("mismatch %s: expected %h, got %h", name, expected, actual);
        errors++;
    endtask

    task automatic reportFailure(input string what);
        $display("failure: %s", what);
        errors++;
    endtask

    function automatic int wordIndex(input logic [31:0] addr, input logic [31:0] base);
        logic [31:0] offset;
        offset = (addr - base) >> 2;
        return int'(offset[idxBits-1:0]);
    endfunction

    function automatic logic [31:0] fillWord(input logic [31:0] addr);
        return addr ^ 32'h5A5A_0F0F;
    endfunction

    function automatic logic [31:0] encodeR(input mipsPkg::functT fn, input logic [4:0] rs,
                                            input logic [4:0] rt, input logic [4:0] rd,
                                            input logic [4:0] shamt);
        return {6'd0, rs, rt, rd, shamt, fn};
    endfunction

    function automatic logic [31:0] encodeI(input mipsPkg::opcodeT op, input logic [4:0] rs,
                                            input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // J to a word of the program image
    function automatic logic [31:0] encodeJ(input int index);
        logic [31:0] addr;
        addr = mipsPkg::resetVector + 32'(index * 4);
        return {mipsPkg::opJ, addr[27:2]};
    endfunction

    task automatic startProgram;
        progLen = 0;
        for (int i = 0; i < memWords; i++)
            prog[i] = '0;
    endtask

    task automatic emit(input logic [31:0] word);
        prog[progLen] = word;
        progLen++;
    endtask

    // JR $0 with a NOP in its delay slot
    task automatic emitHalt;
        emit(encodeR(mipsPkg::fnJr, 5'd0, 5'd0, 5'd0, 5'd0));
        emit(32'd0);
    endtask

    task automatic buildAluProgram(input int numOps);
        logic [4:0] rd;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [15:0] imm;
        int k;
        startProgram();
        for (int r = 1; r < 8; r++) begin
            emit(encodeI(mipsPkg::opLui, 5'd0, 5'(r), 16'($urandom)));
            emit(encodeI(mipsPkg::opOri, 5'(r), 5'(r), 16'($urandom)));
        end
        for (int i = 0; i < numOps; i++) begin
            rd = 5'($urandom_range(7, 0));   // $0 as a target too
            rs = 5'($urandom_range(7, 0));
            rt = 5'($urandom_range(7, 0));
            imm = 16'($urandom);
            k = int'($urandom_range(16, 0));
            if (k < 7)
                emit(encodeR(aluFuncts[k], rs, rt, rd, 5'd0));
            else if (k < 10)
                emit(encodeR(aluFuncts[k], 5'd0, rt, rd, imm[4:0]));
            else
                emit(encodeI(immOps[k - 10], rs, rd, imm));
            emit(encodeI(mipsPkg::opSw, 5'd0, rd, 16'(dataBase + 32'(i * 4))));
        end
        emitHalt();
    endtask

    task automatic buildBranchProgram;
        startProgram();
        emit(encodeI(mipsPkg::opAddiu, 5'd0, 5'd1, 16'd5));        // Loop count
        emit(encodeI(mipsPkg::opAddiu, 5'd0, 5'd3, 16'd0));
        emit(encodeI(mipsPkg::opAddiu, 5'd0, 5'd4, 16'(dataBase)));
        emit(encodeR(mipsPkg::fnAddu, 5'd3, 5'd1, 5'd3, 5'd0));     // Loop top at word 3
        emit(encodeI(mipsPkg::opSw, 5'd4, 5'd3, 16'd0));
        emit(encodeI(mipsPkg::opAddiu, 5'd1, 5'd1, 16'hFFFF));
        emit(encodeI(mipsPkg::opBne, 5'd1, 5'd0, 16'hFFFC));
        emit(encodeI(mipsPkg::opAddiu, 5'd4, 5'd4, 16'd4));         // Delay slot
        emit(encodeI(mipsPkg::opBeq, 5'd1, 5'd0, 16'd2));           // Taken to word 11
        emit(encodeI(mipsPkg::opAddiu, 5'd0, 5'd2, 16'h0077));
        emit(encodeI(mipsPkg::opAddiu, 5'd0, 5'd2, 16'h0055));      // Skipped
        emit(encodeI(mipsPkg::opBeq, 5'd3, 5'd0, 16'd2));           // Not taken
        emit(encodeI(mipsPkg::opAddiu, 5'd0, 5'd5, 16'h0033));
        emit(encodeI(mipsPkg::opAddiu, 5'd5, 5'd5, 16'd1));
        emit(encodeI(mipsPkg::opSw, 5'd4, 5'd5, 16'd0));
        emit(encodeI(mipsPkg::opSw, 5'd4, 5'd2, 16'd4));
        emit(encodeJ(18));
        emit(encodeI(mipsPkg::opAddiu, 5'd2, 5'd2, 16'd1));         // Delay slot of J
        emitHalt();
    endtask

    task automatic buildLoadStoreProgram;
        startProgram();
        emit(encodeI(mipsPkg::opLui, 5'd0, 5'd1, 16'hDEAD));
        emit(encodeI(mipsPkg::opOri, 5'd1, 5'd1, 16'hBEEF));
        emit(encodeI(mipsPkg::opSw, 5'd0, 5'd1, 16'h1000));
        emit(encodeI(mipsPkg::opLw, 5'd0, 5'd6, 16'h1000));         // Reads back the store
        emit(encodeI(mipsPkg::opAddiu, 5'd6, 5'd7, 16'd1));
        emit(encodeI(mipsPkg::opSw, 5'd0, 5'd7, 16'h1004));
        emit(encodeI(mipsPkg::opLw, 5'd0, 5'd8, 16'h1010));         // Untouched fill word
        emit(encodeI(mipsPkg::opSw, 5'd0, 5'd8, 16'h1008));
        emit(encodeI(mipsPkg::opSw, 5'd0, 5'd6, 16'h100C));
        emit(encodeR(mipsPkg::fnAddu, 5'd6, 5'd8, 5'd2, 5'd0));
        emitHalt();
    endtask

    task automatic loadMemory;
        for (int i = 0; i < memWords; i++) begin
            avalonMem_i.progMem[i] = prog[i];
            modelData[i] = fillWord(dataBase + 32'(i * 4));
            avalonMem_i.dataMem[i] = modelData[i];
        end
    endtask

    // Instruction-level reference with one delay slot
    task automatic runModel;
        logic [31:0] pc;
        logic [31:0] nextPc;
        logic [31:0] newNext;
        logic [31:0] instr;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] simm;
        logic [31:0] zimm;
        logic [4:0] dest;
        int count;
        for (int r = 0; r < 32; r++)
            modelRegs[r] = '0;
        expAddr.delete();
        expData.delete();
        pc = mipsPkg::resetVector;
        nextPc = pc + 32'd4;
        count = 0;
        while (pc != mipsPkg::haltAddress && count < maxInstr) begin
            instr = prog[wordIndex(pc, mipsPkg::resetVector)];
            a = modelRegs[instr[25:21]];
            b = modelRegs[instr[20:16]];
            simm = {{16{instr[15]}}, instr[15:0]};
            zimm = {16'd0, instr[15:0]};
            newNext = nextPc + 32'd4;
            dest = instr[20:16];
            res = '0;
            case (instr[31:26])
                mipsPkg::opSpecial: begin
                    dest = instr[15:11];
                    case (instr[5:0])
                        mipsPkg::fnAddu: res = a + b;
                        mipsPkg::fnSubu: res = a - b;
                        mipsPkg::fnAnd:  res = a & b;
                        mipsPkg::fnOr:   res = a | b;
                        mipsPkg::fnXor:  res = a ^ b;
                        mipsPkg::fnSlt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        mipsPkg::fnSltu: res = (a < b) ? 32'd1 : 32'd0;
                        mipsPkg::fnSll:  res = b << instr[10:6];
                        mipsPkg::fnSrl:  res = b >> instr[10:6];
                        mipsPkg::fnSra:  res = $signed(b) >>> instr[10:6];
                        mipsPkg::fnJr: begin
                            newNext = a;
                            dest = '0;
                        end
                        default: dest = '0;
                    endcase
                end
                mipsPkg::opJ: begin
                    newNext = {nextPc[31:28], instr[25:0], 2'b00};
                    dest = '0;
                end
                mipsPkg::opBeq: begin
                    if (a == b)
                        newNext = nextPc + (simm << 2);
                    dest = '0;
                end
                mipsPkg::opBne: begin
                    if (a != b)
                        newNext = nextPc + (simm << 2);
                    dest = '0;
                end
                mipsPkg::opAddiu: res = a + simm;
                mipsPkg::opSlti:  res = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
                mipsPkg::opSltiu: res = (a < simm) ? 32'd1 : 32'd0;
                mipsPkg::opAndi:  res = a & zimm;
                mipsPkg::opOri:   res = a | zimm;
                mipsPkg::opXori:  res = a ^ zimm;
                mipsPkg::opLui:   res = {instr[15:0], 16'd0};
                mipsPkg::opLw:    res = modelData[wordIndex(a + simm, dataBase)];
                mipsPkg::opSw: begin
                    expAddr.push_back(a + simm);
                    expData.push_back(b);
                    modelData[wordIndex(a + simm, dataBase)] = b;
                    dest = '0;
                end
                default: dest = '0;
            endcase
            if (dest != '0)
                modelRegs[dest] = res;
            pc = nextPc;
            nextPc = newNext;
            count++;
        end
        assert (pc == mipsPkg::haltAddress)
            else reportFailure("reference model never reached the halt address");
    endtask

    task automatic checkWrite;
        logic [31:0] expA;
        logic [31:0] expD;
        assert (expAddr.size() > 0) else reportFailure("bus write with no store left to match");
        if (expAddr.size() > 0) begin
            expA = expAddr.pop_front();
            expD = expData.pop_front();
            assert (address == expA) else reportMismatch("address", expA, address);
            assert (writedata == expD) else reportMismatch("writedata", expD, writedata);
        end
    endtask

    // Bus protocol and write checks at mid-cycle
    assign curReq = {address, read, write, writedata};

    always @(negedge clk) begin
        if (reset) begin
            haltSeen = 1'b0;
        end else begin
            assert (byteenable == 4'hF) else reportMismatch("byteenable", 32'hF, 32'(byteenable));
            if (prevWait && (prevReq.read || prevReq.write)) begin
                assert (curReq == prevReq)
                    else reportFailure("bus request changed while waitrequest was high");
            end
            if (write && !waitrequest)
                checkWrite();
            if (haltSeen) begin
                assert (!active) else reportFailure("active rose again after the halt");
                assert (!read && !write) else reportFailure("bus access after the halt");
            end
            if (!active)
                haltSeen = 1'b1;
        end
        prevReq = curReq;
        prevWait = waitrequest;
    end

    task automatic applyReset;
        @(posedge clk);
        #1 reset = 1'b1;
        repeat (resetCycles) @(posedge clk);
        #1 reset = 1'b0;
    endtask

    task automatic runTest(input string name);
        int startErrors;
        startErrors = errors;
        loadMemory();
        runModel();
        applyReset();
        @(posedge clk);
        @(negedge clk);
        assert (active && !write)
            else reportFailure("core not active with write low one cycle after reset");
        while (active)
            @(negedge clk);
        repeat (10) @(negedge clk);   // Bus must stay quiet after the halt
        assert (registerV0 == modelRegs[2])
            else reportMismatch("registerV0", modelRegs[2], registerV0);
        assert (expAddr.size() == 0)
            else reportFailure($sformatf("%0d predicted stores never reached the bus",
                                         expAddr.size()));
        testsRun++;
        if (errors == startErrors) begin
            $display("test %s passed", name);
        end else begin
            $display("test %s failed with %0d errors", name, errors - startErrors);
            testsFailed++;
        end
    endtask

    initial begin
        #(numTests * maxInstr * phases * maxWait * clkPeriod);
        $display("failure: timeout, the core did not halt in time");
        $display("Done: errors found");
        $finish;
    end

    initial begin
        void'($urandom(30923));
        reset = 1'b1;
        errors = 0;
        testsRun = 0;
        testsFailed = 0;
        prevReq = '0;
        prevWait = 1'b0;
        haltSeen = 1'b0;
        for (int t = 0; t < numRandomTests; t++) begin
            buildAluProgram(12);
            runTest($sformatf("aluRandom%0d", t));
        end
        buildBranchProgram();
        runTest("branchLoop");
        buildLoadStoreProgram();
        runTest("loadStore");
        $display("tests run %0d, tests failed %0d, errors %0d", testsRun, testsFailed, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

/* sim.f */
hdl/mipsPkg.sv
hdl/controlFsm.sv
hdl/instrDecode.sv
hdl/regFile.sv
hdl/alu.sv
hdl/pcUnit.sv
hdl/mipsCpuBus.sv
dv/avalonMem.sv
dv/tbMipsCpuBus.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run, then judge the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tbMipsCpuBus -f sim.f -o tbSim \
    && ./obj_dir/tbSim | tee sim.log
grep -qx "Done: no errors" sim.log 2>/dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
